// ==== src/vdp_fmt_pkg.sv ====
`default_nettype none

package vdp_fmt_pkg;

    localparam int vector_lanes = 16;
    localparam int data_width   = 16;
    localparam int frac_bits    = 8;
    localparam int mag_width    = data_width - 1;

    // sign-magnitude element, 7 integer and 8 fraction bits
    typedef struct packed {
        logic                 sign;
        logic [mag_width-1:0] mag;
    } fx_t;

    typedef fx_t [vector_lanes-1:0] vec_t;

    localparam fx_t         fx_one     = '{sign: 1'b0, mag: mag_width'(1 << frac_bits)};
    localparam int unsigned fx_max_mag = 32767;

    // exact product keeps 2*frac_bits fraction bits
    localparam int prod_width = 2 * data_width + 1;
    localparam int pair_width = prod_width + 1;
    localparam int acc_width  = prod_width + 2;

    // magnitude after dropping frac_bits, plus one carry bit for the rounding step
    localparam int trunc_width = acc_width - frac_bits;
    localparam int rnd_width   = trunc_width + 1;

    typedef logic signed [pair_width-1:0] pair_t;
    typedef logic signed [acc_width-1:0]  acc_t;

    // encoding 2'd3 falls back to truncation
    typedef enum logic [1:0] {
        rnd_zero      = 2'd0,
        rnd_near_away = 2'd1,
        rnd_near_even = 2'd2
    } rnd_mode_t;

endpackage

`default_nettype wire

// ==== src/vdp_op_pkg.sv ====
`default_nettype none

package vdp_op_pkg;

    typedef enum logic [2:0] {
        op_mat3 = 3'd0,
        op_dot4 = 3'd1,
        op_qmul = 3'd2,
        op_rot  = 3'd3
    } vdp_op_t;

    // lane result is s0*s1 + s2*s3 + s4*s5 + s6*s7
    typedef struct packed {
        vdp_fmt_pkg::fx_t s0;
        vdp_fmt_pkg::fx_t s1;
        vdp_fmt_pkg::fx_t s2;
        vdp_fmt_pkg::fx_t s3;
        vdp_fmt_pkg::fx_t s4;
        vdp_fmt_pkg::fx_t s5;
        vdp_fmt_pkg::fx_t s6;
        vdp_fmt_pkg::fx_t s7;
    } lane_ops_t;

    typedef lane_ops_t [vdp_fmt_pkg::vector_lanes-1:0] lane_ops_vec_t;

endpackage

`default_nettype wire

// ==== src/operand_router.sv ====
`default_nettype none

module operand_router (
    input  vdp_fmt_pkg::vec_t          vec_a,
    input  vdp_fmt_pkg::vec_t          vec_b,
    input  vdp_fmt_pkg::vec_t          vec_c,
    input  vdp_op_pkg::vdp_op_t        funct,
    output vdp_op_pkg::lane_ops_vec_t  lane_ops
);

    import vdp_fmt_pkg::*;
    import vdp_op_pkg::*;

    vec_t          a_neg;
    lane_ops_vec_t mat_ops;
    lane_ops_vec_t dot_ops;
    lane_ops_vec_t qmul_ops;
    lane_ops_vec_t rot_ops;

    // pairs are (p0,q0) (p1,q1) (p2,q2) (p3,q3)
    function automatic lane_ops_t pack_ops(
        input fx_t p0, input fx_t q0,
        input fx_t p1, input fx_t q1,
        input fx_t p2, input fx_t q2,
        input fx_t p3, input fx_t q3
    );
        pack_ops = '{s0: p0, s1: q0, s2: p1, s3: q1, s4: p2, s5: q2, s6: p3, s7: q3};
    endfunction

    // negation is a sign flip
    for (genvar i = 0; i < vector_lanes; i++) begin : g_neg
        assign a_neg[i] = '{sign: ~vec_a[i].sign, mag: vec_a[i].mag};
    end

    // 3x3 A*B + C, lane 3i+j
    always_comb begin
        mat_ops = '0;
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                mat_ops[3*i+j] = pack_ops(vec_a[j],   vec_b[3*i],
                                          vec_a[3+j], vec_b[3*i+1],
                                          vec_a[6+j], vec_b[3*i+2],
                                          vec_c[3*i+j], fx_one);
            end
        end
    end

    always_comb begin
        dot_ops = '0;
        for (int i = 0; i < vector_lanes / 4; i++) begin
            dot_ops[4*i] = pack_ops(vec_a[4*i],   vec_b[4*i],
                                    vec_a[4*i+1], vec_b[4*i+1],
                                    vec_a[4*i+2], vec_b[4*i+2],
                                    vec_a[4*i+3], vec_b[4*i+3]);
        end
    end

    // hamilton product, q0 = a[0..3], q1 = b[0..3], both (w, x, y, z)
    always_comb begin
        qmul_ops    = '0;
        qmul_ops[0] = pack_ops(vec_a[0], vec_b[0], a_neg[1], vec_b[1],
                               a_neg[2], vec_b[2], a_neg[3], vec_b[3]);
        qmul_ops[1] = pack_ops(vec_a[0], vec_b[1], vec_a[1], vec_b[0],
                               vec_a[2], vec_b[3], a_neg[3], vec_b[2]);
        qmul_ops[2] = pack_ops(vec_a[0], vec_b[2], a_neg[1], vec_b[3],
                               vec_a[2], vec_b[0], vec_a[3], vec_b[1]);
        qmul_ops[3] = pack_ops(vec_a[0], vec_b[3], vec_a[1], vec_b[2],
                               a_neg[2], vec_b[1], vec_a[3], vec_b[0]);
    end

    // rotation matrix from w, x, y, z = a[0..3]
    // doubled cross terms come from both operand orders
    always_comb begin
        rot_ops    = '0;
        rot_ops[0] = pack_ops(vec_a[0], vec_a[0], vec_a[1], vec_a[1],
                              vec_a[2], a_neg[2], vec_a[3], a_neg[3]);
        rot_ops[1] = pack_ops(vec_a[1], vec_a[2], vec_a[2], vec_a[1],
                              vec_a[0], vec_a[3], vec_a[3], vec_a[0]);
        rot_ops[2] = pack_ops(vec_a[1], vec_a[3], vec_a[3], vec_a[1],
                              vec_a[0], a_neg[2], a_neg[2], vec_a[0]);
        rot_ops[3] = pack_ops(vec_a[1], vec_a[2], vec_a[2], vec_a[1],
                              vec_a[0], a_neg[3], a_neg[3], vec_a[0]);
        rot_ops[4] = pack_ops(vec_a[0], vec_a[0], vec_a[1], a_neg[1],
                              vec_a[2], vec_a[2], vec_a[3], a_neg[3]);
        rot_ops[5] = pack_ops(vec_a[2], vec_a[3], vec_a[3], vec_a[2],
                              vec_a[0], vec_a[1], vec_a[1], vec_a[0]);
        rot_ops[6] = pack_ops(vec_a[1], vec_a[3], vec_a[3], vec_a[1],
                              vec_a[0], vec_a[2], vec_a[2], vec_a[0]);
        rot_ops[7] = pack_ops(vec_a[2], vec_a[3], vec_a[3], vec_a[2],
                              vec_a[0], a_neg[1], a_neg[1], vec_a[0]);
        rot_ops[8] = pack_ops(vec_a[0], vec_a[0], vec_a[1], a_neg[1],
                              vec_a[2], a_neg[2], vec_a[3], vec_a[3]);
    end

    always_comb begin
        case (funct)
            op_mat3: lane_ops = mat_ops;
            op_dot4: lane_ops = dot_ops;
            op_qmul: lane_ops = qmul_ops;
            op_rot:  lane_ops = rot_ops;
            default: lane_ops = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/pair_mac.sv ====
`default_nettype none

module pair_mac (
    input  logic               clk,
    input  logic               rst_n,
    input  vdp_fmt_pkg::fx_t   x0,
    input  vdp_fmt_pkg::fx_t   y0,
    input  vdp_fmt_pkg::fx_t   x1,
    input  vdp_fmt_pkg::fx_t   y1,
    output vdp_fmt_pkg::pair_t pair_sum
);

    import vdp_fmt_pkg::*;

    logic signed [data_width-1:0] x0_s;
    logic signed [data_width-1:0] y0_s;
    logic signed [data_width-1:0] x1_s;
    logic signed [data_width-1:0] y1_s;
    logic signed [prod_width-1:0] prod0;
    logic signed [prod_width-1:0] prod1;

    // magnitude is 15 bits so the two's complement form fits in data_width
    function automatic logic signed [data_width-1:0] to_signed(input fx_t v);
        logic signed [data_width-1:0] m;
        m = $signed({1'b0, v.mag});
        to_signed = v.sign ? -m : m;
    endfunction

    assign x0_s = to_signed(x0);
    assign y0_s = to_signed(y0);
    assign x1_s = to_signed(x1);
    assign y1_s = to_signed(y1);

    assign prod0 = prod_width'(x0_s) * prod_width'(y0_s);
    assign prod1 = prod_width'(x1_s) * prod_width'(y1_s);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pair_sum <= '0;
        end else begin
            pair_sum <= pair_t'(prod0) + pair_t'(prod1);
        end
    end

endmodule

`default_nettype wire

// ==== src/dp4_combine.sv ====
`default_nettype none

module dp4_combine (
    input  logic                   clk,
    input  logic                   rst_n,
    input  vdp_fmt_pkg::pair_t     pair_lo,
    input  vdp_fmt_pkg::pair_t     pair_hi,
    input  vdp_fmt_pkg::rnd_mode_t rnd,
    output vdp_fmt_pkg::fx_t       result,
    output logic                   sat
);

    import vdp_fmt_pkg::*;

    acc_t                   acc;
    logic [acc_width-1:0]   abs_acc;
    logic [trunc_width-1:0] trunc_mag;
    logic                   guard;
    logic                   sticky;
    logic                   round_up;
    logic [rnd_width-1:0]   rounded;
    logic                   ovf;
    fx_t                    res_d;

    // exact four-product sum, 16 fraction bits
    assign acc = acc_t'(pair_lo) + acc_t'(pair_hi);

    // magnitude first, so rounding is symmetric about zero
    assign abs_acc   = acc[acc_width-1] ? -acc : acc;
    assign trunc_mag = abs_acc[acc_width-1:frac_bits];
    assign guard     = abs_acc[frac_bits-1];
    assign sticky    = |abs_acc[frac_bits-2:0];

    always_comb begin
        case (rnd)
            rnd_near_away: round_up = guard;
            rnd_near_even: round_up = guard & (sticky | trunc_mag[0]);
            default:       round_up = 1'b0;
        endcase
    end

    assign rounded = {1'b0, trunc_mag} + rnd_width'(round_up);
    assign ovf     = rounded > rnd_width'(fx_max_mag);

    always_comb begin
        res_d.mag  = ovf ? mag_width'(fx_max_mag) : rounded[mag_width-1:0];
        // no negative zero
        res_d.sign = acc[acc_width-1] & (res_d.mag != '0);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
            sat    <= 1'b0;
        end else begin
            result <= res_d;
            sat    <= ovf;
        end
    end

endmodule

`default_nettype wire

// ==== src/dp4_lane.sv ====
`default_nettype none

module dp4_lane (
    input  logic                    clk,
    input  logic                    rst_n,
    input  vdp_op_pkg::lane_ops_t   ops,
    input  vdp_fmt_pkg::rnd_mode_t  rnd,
    output vdp_fmt_pkg::fx_t        result,
    output logic                    sat
);

    import vdp_fmt_pkg::*;

    pair_t pair_lo;
    pair_t pair_hi;

    // both halves of the dot product in parallel
    pair_mac u_pair_lo (
        .clk      (clk),
        .rst_n    (rst_n),
        .x0       (ops.s0),
        .y0       (ops.s1),
        .x1       (ops.s2),
        .y1       (ops.s3),
        .pair_sum (pair_lo)
    );

    pair_mac u_pair_hi (
        .clk      (clk),
        .rst_n    (rst_n),
        .x0       (ops.s4),
        .y0       (ops.s5),
        .x1       (ops.s6),
        .y1       (ops.s7),
        .pair_sum (pair_hi)
    );

    dp4_combine u_combine (
        .clk     (clk),
        .rst_n   (rst_n),
        .pair_lo (pair_lo),
        .pair_hi (pair_hi),
        .rnd     (rnd),
        .result  (result),
        .sat     (sat)
    );

endmodule

`default_nettype wire

// ==== src/vector_dp_unit.sv ====
`default_nettype none

module vector_dp_unit (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  en,
    input  vdp_fmt_pkg::vec_t                     vec_a,
    input  vdp_fmt_pkg::vec_t                     vec_b,
    input  vdp_fmt_pkg::vec_t                     vec_c,
    input  vdp_op_pkg::vdp_op_t                   funct,
    input  vdp_fmt_pkg::rnd_mode_t                rnd,
    output vdp_fmt_pkg::vec_t                     vec_out,
    output logic [vdp_fmt_pkg::vector_lanes-1:0]  sat,
    output logic                                  out_valid
);

    import vdp_fmt_pkg::*;
    import vdp_op_pkg::*;

    lane_ops_vec_t lane_ops;
    rnd_mode_t     rnd_q;
    logic          en_q;

    operand_router u_router (
        .vec_a    (vec_a),
        .vec_b    (vec_b),
        .vec_c    (vec_c),
        .funct    (funct),
        .lane_ops (lane_ops)
    );

    // rounding mode follows the pair sums into the second stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rnd_q     <= rnd_zero;
            en_q      <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            rnd_q     <= rnd;
            en_q      <= en;
            out_valid <= en_q;
        end
    end

    for (genvar i = 0; i < vector_lanes; i++) begin : g_lane
        dp4_lane u_lane (
            .clk    (clk),
            .rst_n  (rst_n),
            .ops    (lane_ops[i]),
            .rnd    (rnd_q),
            .result (vec_out[i]),
            .sat    (sat[i])
        );
    end

endmodule

`default_nettype wire

// ==== tests/vector_dp_unit_asserts.sv ====
`default_nettype none

module vector_dp_unit_asserts (
    input logic                               clk,
    input logic                               rst_n,
    input logic                               en,
    input logic                               out_valid,
    input vdp_fmt_pkg::vec_t                  vec_out
);

    import vdp_fmt_pkg::*;

    logic [1:0] live_cycles;

    // en history is only meaningful two edges after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            live_cycles <= '0;
        end else if (live_cycles != 2'd2) begin
            live_cycles <= live_cycles + 2'd1;
        end
    end

    valid_follows_en: assert property (@(posedge clk) disable iff (!rst_n)
        live_cycles == 2'd2 |-> out_valid == $past(en, 2))
        else $error("out_valid differs from en two cycles earlier");

    valid_low_in_reset: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else $error("out_valid high while in reset");

    for (genvar i = 0; i < vector_lanes; i++) begin : g_lane
        no_neg_zero: assert property (@(posedge clk)
            vec_out[i].sign |-> vec_out[i].mag != '0)
            else $error("negative zero on lane %0d", i);
    end

endmodule

bind vector_dp_unit vector_dp_unit_asserts u_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .en        (en),
    .out_valid (out_valid),
    .vec_out   (vec_out)
);

`default_nettype wire

// ==== tests/tb_vector_dp_unit.sv ====
`default_nettype none

module tb_vector_dp_unit;

    import vdp_fmt_pkg::*;
    import vdp_op_pkg::*;

    localparam int max_cycles = 2000;
    localparam int rand_mag   = 2047;

    // tie and near-tie products for lane 0, magnitudes of a[0] and b[0]
    localparam int unsigned tie_a [8] = '{1, 1, 5, 3, 1, 7, 2, 9};
    localparam int unsigned tie_b [8] = '{128, 128, 128, 100, 200, 64, 192, 160};

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    en;
    vec_t                    vec_a;
    vec_t                    vec_b;
    vec_t                    vec_c;
    vdp_op_t                 funct;
    rnd_mode_t               rnd;
    vec_t                    vec_out;
    logic [vector_lanes-1:0] sat;
    logic                    out_valid;

    int cycle_count  = 0;
    int vec_errors   = 0;
    int sat_errors   = 0;
    int valid_errors = 0;

    vector_dp_unit u_vector_dp_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .vec_a     (vec_a),
        .vec_b     (vec_b),
        .vec_c     (vec_c),
        .funct     (funct),
        .rnd       (rnd),
        .vec_out   (vec_out),
        .sat       (sat),
        .out_valid (out_valid)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("run stopped after %0d cycles without reaching the end", cycle_count);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic longint fx_to_int(input fx_t v);
        return v.sign ? -longint'(v.mag) : longint'(v.mag);
    endfunction

    function automatic fx_t int_to_fx(input longint x);
        fx_t r;
        r.sign = (x < 0);
        r.mag  = mag_width'(x < 0 ? -x : x);
        return r;
    endfunction

    // zero magnitudes always get a positive sign
    function automatic vec_t rand_vec(input int unsigned max_mag);
        vec_t v;
        for (int i = 0; i < vector_lanes; i++) begin
            v[i].mag  = mag_width'($urandom_range(max_mag, 0));
            v[i].sign = (v[i].mag != '0) && ($urandom_range(1, 0) == 1);
        end
        return v;
    endfunction

    // exact lane sum with 16 fraction bits
    function automatic longint exact_sum(input vec_t a, input vec_t b, input vec_t c,
                                         input vdp_op_t op, input int lane);
        longint av [vector_lanes];
        longint bv [vector_lanes];
        longint w;
        longint x;
        longint y;
        longint z;
        int     i;
        int     j;
        for (int k = 0; k < vector_lanes; k++) begin
            av[k] = fx_to_int(a[k]);
            bv[k] = fx_to_int(b[k]);
        end
        w = av[0];
        x = av[1];
        y = av[2];
        z = av[3];
        i = lane / 3;
        j = lane % 3;
        case (op)
            op_mat3: if (lane < 9) return av[j] * bv[3*i] + av[3+j] * bv[3*i+1]
                                        + av[6+j] * bv[3*i+2] + fx_to_int(c[lane]) * 256;
            op_dot4: if (lane % 4 == 0) return av[lane] * bv[lane] + av[lane+1] * bv[lane+1]
                                               + av[lane+2] * bv[lane+2] + av[lane+3] * bv[lane+3];
            op_qmul: case (lane)
                0: return w * bv[0] - x * bv[1] - y * bv[2] - z * bv[3];
                1: return w * bv[1] + x * bv[0] + y * bv[3] - z * bv[2];
                2: return w * bv[2] - x * bv[3] + y * bv[0] + z * bv[1];
                3: return w * bv[3] + x * bv[2] - y * bv[1] + z * bv[0];
                default: ;
            endcase
            op_rot: case (lane)
                0: return w * w + x * x - y * y - z * z;
                1: return 2 * (x * y + w * z);
                2: return 2 * (x * z - w * y);
                3: return 2 * (x * y - w * z);
                4: return w * w - x * x + y * y - z * z;
                5: return 2 * (y * z + w * x);
                6: return 2 * (x * z + w * y);
                7: return 2 * (y * z - w * x);
                8: return w * w - x * x - y * y + z * z;
                default: ;
            endcase
            default: ;
        endcase
        return 0;
    endfunction

    task automatic model_vec(input vec_t a, input vec_t b, input vec_t c, input vdp_op_t op,
                             input rnd_mode_t mode, output vec_t exp,
                             output logic [vector_lanes-1:0] exp_sat);
        longint s;
        longint mag;
        longint q;
        longint rem;
        logic   up;
        for (int i = 0; i < vector_lanes; i++) begin
            s   = exact_sum(a, b, c, op, i);
            mag = s < 0 ? -s : s;
            q   = mag / 256;
            rem = mag % 256;
            case (mode)
                rnd_near_away: up = (rem >= 128);
                rnd_near_even: up = (rem > 128) || (rem == 128 && q % 2 == 1);
                default:       up = 1'b0;
            endcase
            q          = q + longint'(up);
            exp_sat[i] = (q > longint'(fx_max_mag));
            if (exp_sat[i]) begin
                q = longint'(fx_max_mag);
            end
            exp[i] = int_to_fx(s < 0 ? -q : q);
        end
    endtask

    task automatic check_vec(input vec_t got, input vec_t exp, input string what);
        for (int i = 0; i < vector_lanes; i++) begin
            if (got[i] !== exp[i]) begin
                $display("FAIL %0t %s lane %0d: got %h expected %h",
                         $time, what, i, got[i], exp[i]);
                vec_errors++;
            end
        end
    endtask

    task automatic check_sat(input logic [vector_lanes-1:0] got,
                             input logic [vector_lanes-1:0] exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t %s sat: got %h expected %h", $time, what, got, exp);
            sat_errors++;
        end
    endtask

    task automatic check_valid(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t %s out_valid: got %b expected %b", $time, what, got, exp);
            valid_errors++;
        end
    endtask

    task automatic drive(input logic strobe, input vec_t a, input vec_t b, input vec_t c,
                         input vdp_op_t op, input rnd_mode_t mode);
        @(posedge clk);
        en    <= strobe;
        vec_a <= a;
        vec_b <= b;
        vec_c <= c;
        funct <= op;
        rnd   <= mode;
    endtask

    task automatic run_expect(input vec_t a, input vec_t b, input vec_t c, input vdp_op_t op,
                              input rnd_mode_t mode, input vec_t exp,
                              input logic [vector_lanes-1:0] exp_sat, input string what);
        logic seen;
        drive(1'b1, a, b, c, op, mode);
        @(posedge clk);
        en   <= 1'b0;
        seen = 1'b0;
        for (int k = 0; k < 4 && !seen; k++) begin
            @(negedge clk);
            seen = out_valid;
        end
        if (!seen) begin
            $display("%s: out_valid never rose after the operation was issued", what);
            valid_errors++;
        end else begin
            check_vec(vec_out, exp, what);
            check_sat(sat, exp_sat, what);
        end
    endtask

    task automatic run_op(input vec_t a, input vec_t b, input vec_t c, input vdp_op_t op,
                          input rnd_mode_t mode, input string what);
        vec_t                    exp;
        logic [vector_lanes-1:0] exp_sat;
        model_vec(a, b, c, op, mode, exp, exp_sat);
        run_expect(a, b, c, op, mode, exp, exp_sat, what);
    endtask

    task automatic test_dot4();
        vec_t a;
        vec_t b;
        vec_t exp;
        a = rand_vec(rand_mag);
        b = rand_vec(rand_mag);
        run_op(a, b, '0, op_dot4, rnd_near_even, "dot4 random");
        b   = '0;
        exp = '0;
        for (int i = 0; i < 4; i++) begin
            b[4*i]   = fx_one;
            exp[4*i] = a[4*i];
        end
        run_expect(a, b, '0, op_dot4, rnd_zero, exp, '0, "dot4 times one");
    endtask

    task automatic test_mat3();
        vec_t a;
        vec_t b;
        vec_t c;
        vec_t exp;
        a = rand_vec(rand_mag);
        b = rand_vec(rand_mag);
        c = rand_vec(rand_mag);
        run_op(a, b, c, op_mat3, rnd_near_away, "mat3 random");
        b    = '0;
        b[0] = fx_one;
        b[4] = fx_one;
        b[8] = fx_one;
        exp  = '0;
        for (int k = 0; k < 9; k++) begin
            exp[k] = int_to_fx(fx_to_int(a[k]) + fx_to_int(c[k]));
        end
        run_expect(a, b, c, op_mat3, rnd_zero, exp, '0, "mat3 identity");
    endtask

    task automatic test_quat();
        vec_t a;
        vec_t b;
        vec_t exp;
        a = rand_vec(rand_mag);
        b = rand_vec(rand_mag);
        run_op(a, b, '0, op_qmul, rnd_near_even, "qmul random");
        a    = '0;
        a[0] = fx_one;
        exp  = '0;
        for (int k = 0; k < 4; k++) begin
            exp[k] = b[k];
        end
        run_expect(a, b, '0, op_qmul, rnd_zero, exp, '0, "qmul unit");
        run_op(rand_vec(rand_mag), '0, '0, op_rot, rnd_near_away, "rot random");
        exp    = '0;
        exp[0] = fx_one;
        exp[4] = fx_one;
        exp[8] = fx_one;
        run_expect(a, '0, '0, op_rot, rnd_near_even, exp, '0, "rot identity");
    endtask

    task automatic test_round_sat();
        vec_t a;
        vec_t b;
        vec_t exp;
        for (int k = 0; k < 8; k++) begin
            for (int m = 0; m < 4; m++) begin
                a    = '0;
                b    = '0;
                a[0] = '{sign: (k % 2 == 1), mag: mag_width'(tie_a[k])};
                b[0] = '{sign: 1'b0, mag: mag_width'(tie_b[k])};
                run_op(a, b, '0, op_dot4, rnd_mode_t'(2'(m)), "rounding");
            end
        end
        a = '0;
        b = '0;
        for (int k = 0; k < 8; k++) begin
            a[k] = '{sign: (k >= 4), mag: 15'd32512};
            b[k] = '{sign: 1'b0, mag: 15'd32512};
        end
        exp    = '0;
        exp[0] = '{sign: 1'b0, mag: mag_width'(fx_max_mag)};
        exp[4] = '{sign: 1'b1, mag: mag_width'(fx_max_mag)};
        run_expect(a, b, '0, op_dot4, rnd_near_away, exp, 16'h0011, "saturation");
    endtask

    // outputs of op t are checked two iterations later
    task automatic test_pipeline(input int n_ops);
        vec_t                    exp;
        vdp_op_t                 op;
        rnd_mode_t               mode;
        logic [vector_lanes-1:0] exp_sat;
        logic                    issue;
        vec_t                    exp_q [$];
        logic [vector_lanes-1:0] sat_q [$];
        logic                    valid_q [$];
        vec_t                    a;
        vec_t                    b;
        vec_t                    c;
        for (int t = 0; t < n_ops + 2; t++) begin
            if (t < n_ops) begin
                a     = rand_vec(rand_mag);
                b     = rand_vec(rand_mag);
                c     = rand_vec(rand_mag);
                op    = vdp_op_t'(3'($urandom_range(7, 0)));
                mode  = rnd_mode_t'(2'($urandom_range(3, 0)));
                issue = ($urandom_range(3, 0) != 0);
                model_vec(a, b, c, op, mode, exp, exp_sat);
                exp_q.push_back(exp);
                sat_q.push_back(exp_sat);
                valid_q.push_back(issue);
                drive(issue, a, b, c, op, mode);
            end else begin
                @(posedge clk);
                en <= 1'b0;
            end
            @(negedge clk);
            if (t >= 2) begin
                exp     = exp_q.pop_front();
                exp_sat = sat_q.pop_front();
                issue   = valid_q.pop_front();
                check_valid(out_valid, issue, "pipeline");
                if (issue) begin
                    check_vec(vec_out, exp, "pipeline");
                    check_sat(sat, exp_sat, "pipeline");
                end
            end
        end
    endtask

    initial begin
        void'($urandom(32'he072_2b34));
        rst_n = 1'b0;
        en    = 1'b0;
        vec_a = '0;
        vec_b = '0;
        vec_c = '0;
        funct = op_mat3;
        rnd   = rnd_zero;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_vec(vec_out, '0, "after reset");
        check_sat(sat, '0, "after reset");
        check_valid(out_valid, 1'b0, "after reset");
        test_dot4();
        test_mat3();
        test_quat();
        test_round_sat();
        test_pipeline(40);
        repeat (3) @(posedge clk);
        $display("error counts: vec %0d, sat %0d, valid %0d", vec_errors, sat_errors,
                 valid_errors);
        if (vec_errors + sat_errors + valid_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
src/vdp_fmt_pkg.sv
src/vdp_op_pkg.sv
src/operand_router.sv
src/pair_mac.sv
src/dp4_combine.sv
src/dp4_lane.sv
src/vector_dp_unit.sv
tests/vector_dp_unit_asserts.sv
tests/tb_vector_dp_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_vector_dp_unit \
    -f sim.f \
    -o tb_vector_dp_unit

./obj_dir/tb_vector_dp_unit > sim.log 2>&1 || { cat sim.log; echo "simulator exited with an error"; exit 1; }
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
grep -q "Simulation finished: PASS" sim.log
